// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_alu.sv
  - verilog/rv_fetch.sv
  - verilog/rv_decode.sv
  - verilog/rv_execute.sv
  - verilog/rv_mem_wb.sv
  - verilog/rv_core_top.sv
  - target: simulation
    files:
      - verif/rv_core_props.sv
      - verif/rv_core_tb.sv

// File: sim.f
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_core_top.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

// File: verif/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props import rv_pkg::*; #(
	parameter int IMEM_AW = 12
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic [IMEM_AW-1:0] i_mem_addr,
	input  logic               rf_we,
	input  logic [REG_AW-1:0]  rf_wa,
	input  logic               d_mem_we
);

	// read by the testbench
	int fail_count;

	// no stage is occupied right after a reset edge
	a_quiet_after_reset: assert property (@(posedge CLK) RSTn |=> !rf_we && !d_mem_we)
		else begin
			fail_count++;
			$error("register or memory write in the cycle after reset");
		end

	a_no_x0_write: assert property (@(posedge CLK) disable iff (RSTn) !(rf_we && rf_wa == '0))
		else begin
			fail_count++;
			$error("register write to x0");
		end

	// straight-line fetch
	a_pc_step: assert property (@(posedge CLK) disable iff (RSTn)
		!$past(RSTn) |-> i_mem_addr == $past(i_mem_addr) + IMEM_AW'(4))
		else begin
			fail_count++;
			$error("fetch address did not advance by 4");
		end

endmodule

bind rv_core_top rv_core_props #(.IMEM_AW(IMEM_AW)) u_props (.*);

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

	localparam int IMEM_AW = 12;
	localparam int DMEM_AW = 12;
	localparam int DMEM_WORDS = 1 << DMEM_AW;
	localparam int TIMEOUT = 200;
	localparam logic [2:0] F3_W = 3'b010;
	// addi x0, x0, 0
	localparam logic [31:0] NOP = {25'd0, OP_IMM};

	logic               CLK;
	logic               RSTn;
	logic [IMEM_AW-1:0] i_mem_addr;
	logic [XLEN-1:0]    i_mem_rdata;
	logic [REG_AW-1:0]  rf_ra1;
	logic [REG_AW-1:0]  rf_ra2;
	logic [XLEN-1:0]    rf_rd1;
	logic [XLEN-1:0]    rf_rd2;
	logic               rf_we;
	logic [REG_AW-1:0]  rf_wa;
	logic [XLEN-1:0]    rf_wd;
	logic [DMEM_AW-1:0] d_mem_addr;
	logic [XLEN-1:0]    d_mem_wdata;
	logic               d_mem_we;
	logic [XLEN-1:0]    d_mem_rdata;
	logic [31:0]        num_inst;

	logic [XLEN-1:0] regs [0:31];
	logic [XLEN-1:0] dmem [0:DMEM_WORDS-1];
	logic [XLEN-1:0] dmem_ref [0:DMEM_WORDS-1];

	// program and expected results
	logic [31:0]        prog [$];
	logic [REG_AW-1:0]  exp_wa [$];
	logic [XLEN-1:0]    exp_wd [$];
	logic [DMEM_AW-1:0] exp_sa [$];
	logic [XLEN-1:0]    exp_sd [$];
	// observed writes
	logic [REG_AW-1:0]  got_wa [$];
	logic [XLEN-1:0]    got_wd [$];
	logic [DMEM_AW-1:0] got_sa [$];
	logic [XLEN-1:0]    got_sd [$];

	rv_core_top #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) dut (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// register file and data memory, combinational read
	assign rf_rd1 = (rf_ra1 == '0) ? '0 : regs[rf_ra1];
	assign rf_rd2 = (rf_ra2 == '0) ? '0 : regs[rf_ra2];
	assign d_mem_rdata = dmem[d_mem_addr];

	always @(posedge CLK) begin
		if (rf_we === 1'b1 && rf_wa != '0)
			regs[rf_wa] <= rf_wd;
		if (d_mem_we === 1'b1)
			dmem[d_mem_addr] <= d_mem_wdata;
	end

	always @(negedge CLK) begin
		if (rf_we === 1'b1) begin
			got_wa.push_back(rf_wa);
			got_wd.push_back(rf_wd);
		end
		if (d_mem_we === 1'b1) begin
			got_sa.push_back(d_mem_addr);
			got_sd.push_back(d_mem_wdata);
		end
	end

	always @(negedge CLK) begin
		if (dut.u_props.fail_count != 0) begin
			$display("a bound assertion on the core failed");
			$display(">>> FAIL");
			$fatal(1, "assertion failure");
		end
	end

	task automatic check_eq(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [11:0] imm,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, F3_W, imm[4:0], OP_STORE};
	endfunction

	task automatic add_op(input logic [31:0] instr, input logic [4:0] rd,
			input logic [31:0] value);
		prog.push_back(instr);
		if (rd != '0) begin
			exp_wa.push_back(rd);
			exp_wd.push_back(value);
		end
	endtask

	task automatic add_store(input logic [31:0] instr, input logic [DMEM_AW-1:0] waddr,
			input logic [31:0] data);
		prog.push_back(instr);
		exp_sa.push_back(waddr);
		exp_sd.push_back(data);
	endtask

	// x1=19 x2=5 x3=-16 x4=0x80000001 x5=0x100
	task automatic build_program();
		logic [31:0] m64;
		m64 = dmem_ref[64];
		// register-register
		add_op(r_type(7'h00, 2, 1, F3_ADD, 6), 6, 32'h0000_0018);
		add_op(r_type(7'h20, 1, 2, F3_ADD, 7), 7, 32'hFFFF_FFF2);
		add_op(r_type(7'h00, 2, 1, F3_SLL, 8), 8, 32'h0000_0260);
		add_op(r_type(7'h00, 1, 3, F3_SLT, 9), 9, 32'h0000_0001);
		add_op(r_type(7'h00, 1, 3, F3_SLTU, 10), 10, 32'h0000_0000);
		add_op(r_type(7'h00, 3, 1, F3_XOR, 11), 11, 32'hFFFF_FFE3);
		add_op(r_type(7'h00, 2, 3, F3_SR, 12), 12, 32'h07FF_FFFF);
		add_op(r_type(7'h20, 2, 4, F3_SR, 13), 13, 32'hFC00_0000);
		add_op(r_type(7'h00, 4, 1, F3_OR, 14), 14, 32'h8000_0013);
		add_op(r_type(7'h00, 4, 3, F3_AND, 15), 15, 32'h8000_0000);
		// register-immediate
		add_op(i_type(OP_IMM, 12'hFFB, 3, F3_ADD, 16), 16, 32'hFFFF_FFEB);
		add_op(i_type(OP_IMM, 12'h004, 3, F3_SLT, 17), 17, 32'h0000_0001);
		add_op(i_type(OP_IMM, 12'h004, 3, F3_SLTU, 18), 18, 32'h0000_0000);
		add_op(i_type(OP_IMM, 12'h7FF, 1, F3_XOR, 19), 19, 32'h0000_07EC);
		add_op(i_type(OP_IMM, 12'hF00, 2, F3_OR, 20), 20, 32'hFFFF_FF05);
		add_op(i_type(OP_IMM, 12'h0FF, 4, F3_AND, 21), 21, 32'h0000_0001);
		add_op(i_type(OP_IMM, 12'h008, 1, F3_SLL, 22), 22, 32'h0000_1300);
		add_op(i_type(OP_IMM, 12'h004, 4, F3_SR, 23), 23, 32'h0800_0000);
		add_op(i_type(OP_IMM, 12'h402, 3, F3_SR, 24), 24, 32'hFFFF_FFFC);
		// dependency chain at distances 1, 2 and 3
		add_op(i_type(OP_IMM, 12'h001, 1, F3_ADD, 25), 25, 32'h0000_0014);
		add_op(r_type(7'h00, 2, 25, F3_ADD, 26), 26, 32'h0000_0019);
		add_op(r_type(7'h00, 25, 26, F3_ADD, 27), 27, 32'h0000_002D);
		add_op(r_type(7'h20, 25, 27, F3_ADD, 28), 28, 32'h0000_0019);
		add_op(r_type(7'h00, 27, 26, F3_OR, 29), 29, 32'h0000_003D);
		add_op(r_type(7'h00, 29, 29, F3_ADD, 30), 30, 32'h0000_007A);
		// x6 rewritten twice, newest value must win
		add_op(i_type(OP_IMM, 12'h007, 0, F3_ADD, 6), 6, 32'h0000_0007);
		add_op(i_type(OP_IMM, 12'h001, 6, F3_ADD, 6), 6, 32'h0000_0008);
		add_op(r_type(7'h00, 6, 6, F3_ADD, 31), 31, 32'h0000_0010);
		// stores, then loads and load-use
		add_store(s_type(12'h008, 31, 5), 66, 32'h0000_0010);
		add_store(s_type(12'hFFC, 30, 5), 63, 32'h0000_007A);
		add_op(i_type(OP_LOAD, 12'h008, 5, F3_W, 7), 7, 32'h0000_0010);
		add_op(i_type(OP_IMM, 12'h003, 7, F3_ADD, 8), 8, 32'h0000_0013);
		add_op(i_type(OP_LOAD, 12'h000, 5, F3_W, 9), 9, m64);
		add_op(r_type(7'h00, 1, 9, F3_ADD, 10), 10, m64 + 32'd19);
		// x0 destinations write nothing
		add_op(i_type(OP_IMM, 12'h005, 1, F3_ADD, 0), 0, 32'h0);
		add_op(r_type(7'h00, 2, 1, F3_ADD, 0), 0, 32'h0);
		add_op(r_type(7'h00, 1, 10, F3_ADD, 11), 11, m64 + 32'd38);
	endtask

	initial begin
		int k;
		int cycles;
		int unsigned seed_val;
		RSTn <= 1'b1;
		i_mem_rdata <= NOP;
		seed_val = $urandom(32'haece_c674);
		for (k = 0; k < DMEM_WORDS; k++) begin
			dmem[k] = $urandom;
			dmem_ref[k] = dmem[k];
		end
		for (k = 0; k < 32; k++)
			regs[k] = '0;
		regs[1] = 32'h0000_0013;
		regs[2] = 32'h0000_0005;
		regs[3] = 32'hFFFF_FFF0;
		regs[4] = 32'h8000_0001;
		regs[5] = 32'h0000_0100;
		build_program();

		repeat (3) @(posedge CLK);
		RSTn <= 1'b0;
		// one instruction per cycle, fetch address known in advance
		for (k = 0; k < prog.size(); k++) begin
			if (k > 0)
				@(posedge CLK);
			i_mem_rdata <= prog[k];
			@(negedge CLK);
			check_eq("i_mem_addr", 32'(i_mem_addr), 32'(k * 4));
			if (k < 4) begin
				check_eq("rf_we", 32'(rf_we), 32'd0);
				check_eq("d_mem_we", 32'(d_mem_we), 32'd0);
				check_eq("num_inst", num_inst, 32'd0);
			end
		end
		@(posedge CLK);
		i_mem_rdata <= NOP;

		cycles = 0;
		while (got_wa.size() < exp_wa.size() && cycles < TIMEOUT) begin
			@(posedge CLK);
			cycles++;
		end
		if (got_wa.size() < exp_wa.size()) begin
			$display("timeout: only %0d of %0d register writes seen", got_wa.size(),
				exp_wa.size());
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
		// last writeback seen, its retire lands on this edge
		@(negedge CLK);
		check_eq("num_inst", num_inst, 32'(prog.size()));

		check_eq("register write count", 32'(got_wa.size()), 32'(exp_wa.size()));
		for (k = 0; k < exp_wa.size(); k++) begin
			check_eq($sformatf("rf_wa[%0d]", k), 32'(got_wa[k]), 32'(exp_wa[k]));
			check_eq($sformatf("rf_wd[%0d]", k), got_wd[k], exp_wd[k]);
		end
		check_eq("store count", 32'(got_sa.size()), 32'(exp_sa.size()));
		for (k = 0; k < exp_sa.size(); k++) begin
			check_eq($sformatf("d_mem_addr[%0d]", k), 32'(got_sa[k]), 32'(exp_sa[k]));
			check_eq($sformatf("d_mem_wdata[%0d]", k), got_sd[k], exp_sd[k]);
		end

		if (dut.u_props.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("bound assertions on the core reported failures");
			$display(">>> FAIL");
			$fatal(1, "assertion failure");
		end
	end

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
	input  alu_op_e         op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] result
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	// only the low five bits count for shifts
	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			// sign fill from bit 31
			ALU_SRA:  result = XLEN'($signed(a) >>> shamt);
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

endmodule

// File: verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
	parameter int IMEM_AW = 12,
	parameter int DMEM_AW = 12
) (
	input  logic               CLK,
	input  logic               RSTn,
	output logic [IMEM_AW-1:0] i_mem_addr,
	input  logic [XLEN-1:0]    i_mem_rdata,
	output logic [REG_AW-1:0]  rf_ra1,
	output logic [REG_AW-1:0]  rf_ra2,
	input  logic [XLEN-1:0]    rf_rd1,
	input  logic [XLEN-1:0]    rf_rd2,
	output logic               rf_we,
	output logic [REG_AW-1:0]  rf_wa,
	output logic [XLEN-1:0]    rf_wd,
	output logic [DMEM_AW-1:0] d_mem_addr,
	output logic [XLEN-1:0]    d_mem_wdata,
	output logic               d_mem_we,
	input  logic [XLEN-1:0]    d_mem_rdata,
	output logic [31:0]        num_inst
);

	// IF/ID
	logic               if_valid;
	logic [XLEN-1:0]    if_instr;
	logic [IMEM_AW-1:0] if_pc;

	// ID/EX
	logic               id_valid;
	logic [XLEN-1:0]    id_op_a;
	logic [XLEN-1:0]    id_op_b_reg;
	logic [XLEN-1:0]    id_imm;
	logic               id_use_imm;
	alu_op_e            id_alu_op;
	logic [REG_AW-1:0]  id_rs1;
	logic [REG_AW-1:0]  id_rs2;
	logic [REG_AW-1:0]  id_rd;
	logic               id_reg_we;
	logic               id_store;
	logic               id_load;
	logic [IMEM_AW-1:0] id_pc;

	// EX/MEM
	logic               ex_valid;
	logic [XLEN-1:0]    ex_result;
	logic [XLEN-1:0]    ex_store_data;
	logic [REG_AW-1:0]  ex_rd;
	logic               ex_reg_we;
	logic               ex_store;
	logic               ex_load;
	logic [IMEM_AW-1:0] ex_pc;

	// memory-stage forward path
	logic               mem_fwd_we;
	logic [REG_AW-1:0]  mem_fwd_rd;
	logic [XLEN-1:0]    mem_fwd_val;

	rv_fetch #(.IMEM_AW(IMEM_AW)) u_fetch (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.i_mem_rdata (i_mem_rdata),
		.i_mem_addr  (i_mem_addr),
		.if_valid    (if_valid),
		.if_instr    (if_instr),
		.if_pc       (if_pc)
	);

	rv_decode #(.IMEM_AW(IMEM_AW)) u_decode (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.if_valid    (if_valid),
		.if_instr    (if_instr),
		.if_pc       (if_pc),
		.rf_rd1      (rf_rd1),
		.rf_rd2      (rf_rd2),
		.wb_we       (rf_we),
		.wb_wa       (rf_wa),
		.wb_wd       (rf_wd),
		.rf_ra1      (rf_ra1),
		.rf_ra2      (rf_ra2),
		.id_valid    (id_valid),
		.id_op_a     (id_op_a),
		.id_op_b_reg (id_op_b_reg),
		.id_imm      (id_imm),
		.id_use_imm  (id_use_imm),
		.id_alu_op   (id_alu_op),
		.id_rs1      (id_rs1),
		.id_rs2      (id_rs2),
		.id_rd       (id_rd),
		.id_reg_we   (id_reg_we),
		.id_store    (id_store),
		.id_load     (id_load),
		.id_pc       (id_pc)
	);

	rv_execute #(.IMEM_AW(IMEM_AW)) u_execute (
		.CLK           (CLK),
		.RSTn          (RSTn),
		.id_valid      (id_valid),
		.id_op_a       (id_op_a),
		.id_op_b_reg   (id_op_b_reg),
		.id_imm        (id_imm),
		.id_use_imm    (id_use_imm),
		.id_alu_op     (id_alu_op),
		.id_rs1        (id_rs1),
		.id_rs2        (id_rs2),
		.id_rd         (id_rd),
		.id_reg_we     (id_reg_we),
		.id_store      (id_store),
		.id_load       (id_load),
		.id_pc         (id_pc),
		.mem_fwd_we    (mem_fwd_we),
		.mem_fwd_rd    (mem_fwd_rd),
		.mem_fwd_val   (mem_fwd_val),
		.wb_we         (rf_we),
		.wb_wa         (rf_wa),
		.wb_wd         (rf_wd),
		.ex_valid      (ex_valid),
		.ex_result     (ex_result),
		.ex_store_data (ex_store_data),
		.ex_rd         (ex_rd),
		.ex_reg_we     (ex_reg_we),
		.ex_store      (ex_store),
		.ex_load       (ex_load),
		.ex_pc         (ex_pc)
	);

	rv_mem_wb #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_mem_wb (
		.CLK           (CLK),
		.RSTn          (RSTn),
		.ex_valid      (ex_valid),
		.ex_result     (ex_result),
		.ex_store_data (ex_store_data),
		.ex_rd         (ex_rd),
		.ex_reg_we     (ex_reg_we),
		.ex_store      (ex_store),
		.ex_load       (ex_load),
		.ex_pc         (ex_pc),
		.d_mem_rdata   (d_mem_rdata),
		.d_mem_addr    (d_mem_addr),
		.d_mem_wdata   (d_mem_wdata),
		.d_mem_we      (d_mem_we),
		.mem_fwd_we    (mem_fwd_we),
		.mem_fwd_rd    (mem_fwd_rd),
		.mem_fwd_val   (mem_fwd_val),
		.rf_we         (rf_we),
		.rf_wa         (rf_wa),
		.rf_wd         (rf_wd),
		.num_inst      (num_inst)
	);

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; #(
	parameter int IMEM_AW = 12
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               if_valid,
	input  logic [XLEN-1:0]    if_instr,
	input  logic [IMEM_AW-1:0] if_pc,
	input  logic [XLEN-1:0]    rf_rd1,
	input  logic [XLEN-1:0]    rf_rd2,
	input  logic               wb_we,
	input  logic [REG_AW-1:0]  wb_wa,
	input  logic [XLEN-1:0]    wb_wd,
	output logic [REG_AW-1:0]  rf_ra1,
	output logic [REG_AW-1:0]  rf_ra2,
	output logic               id_valid,
	output logic [XLEN-1:0]    id_op_a,
	output logic [XLEN-1:0]    id_op_b_reg,
	output logic [XLEN-1:0]    id_imm,
	output logic               id_use_imm,
	output alu_op_e            id_alu_op,
	output logic [REG_AW-1:0]  id_rs1,
	output logic [REG_AW-1:0]  id_rs2,
	output logic [REG_AW-1:0]  id_rd,
	output logic               id_reg_we,
	output logic               id_store,
	output logic               id_load,
	output logic [IMEM_AW-1:0] id_pc
);

	logic [6:0]        opcode;
	logic [2:0]        f3;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   imm;
	logic [XLEN-1:0]   rs1_val;
	logic [XLEN-1:0]   rs2_val;
	logic              is_alu;
	logic              reg_we;
	alu_op_e           alu_op;

	assign opcode = if_instr[6:0];
	assign f3     = if_instr[14:12];
	assign rd     = if_instr[11:7];
	assign rf_ra1 = if_instr[19:15];
	assign rf_ra2 = if_instr[24:20];

	// S-type splits the immediate around rd
	assign imm = (opcode == OP_STORE) ?
		{{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]} :
		{{20{if_instr[31]}}, if_instr[31:20]};

	assign is_alu = (opcode == OP_R) || (opcode == OP_IMM);
	assign reg_we = (is_alu || (opcode == OP_LOAD)) && (rd != '0);

	always_comb begin
		alu_op = ALU_ADD;
		if (is_alu) begin
			case (f3)
				F3_ADD:  alu_op = (opcode == OP_R && if_instr[30]) ? ALU_SUB : ALU_ADD;
				F3_SLL:  alu_op = ALU_SLL;
				F3_SLT:  alu_op = ALU_SLT;
				F3_SLTU: alu_op = ALU_SLTU;
				F3_XOR:  alu_op = ALU_XOR;
				F3_SR:   alu_op = if_instr[30] ? ALU_SRA : ALU_SRL;
				F3_OR:   alu_op = ALU_OR;
				F3_AND:  alu_op = ALU_AND;
				default: alu_op = ALU_ADD;
			endcase
		end
	end

	// writeback lands this edge, regfile read is still old
	assign rs1_val = fwd_hit(wb_we, wb_wa, rf_ra1) ? wb_wd : rf_rd1;
	assign rs2_val = fwd_hit(wb_we, wb_wa, rf_ra2) ? wb_wd : rf_rd2;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			id_valid  <= 1'b0;
			id_reg_we <= 1'b0;
			id_store  <= 1'b0;
		end else begin
			id_valid  <= if_valid;
			id_reg_we <= if_valid && reg_we;
			id_store  <= if_valid && (opcode == OP_STORE);
		end
	end

	// ID/EX payload
	always_ff @(posedge CLK) begin
		id_op_a     <= rs1_val;
		id_op_b_reg <= rs2_val;
		id_imm      <= imm;
		id_use_imm  <= (opcode != OP_R);
		id_alu_op   <= alu_op;
		id_rs1      <= rf_ra1;
		id_rs2      <= rf_ra2;
		id_rd       <= rd;
		id_load     <= (opcode == OP_LOAD);
		id_pc       <= if_pc;
	end

endmodule

// File: verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; #(
	parameter int IMEM_AW = 12
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               id_valid,
	input  logic [XLEN-1:0]    id_op_a,
	input  logic [XLEN-1:0]    id_op_b_reg,
	input  logic [XLEN-1:0]    id_imm,
	input  logic               id_use_imm,
	input  alu_op_e            id_alu_op,
	input  logic [REG_AW-1:0]  id_rs1,
	input  logic [REG_AW-1:0]  id_rs2,
	input  logic [REG_AW-1:0]  id_rd,
	input  logic               id_reg_we,
	input  logic               id_store,
	input  logic               id_load,
	input  logic [IMEM_AW-1:0] id_pc,
	input  logic               mem_fwd_we,
	input  logic [REG_AW-1:0]  mem_fwd_rd,
	input  logic [XLEN-1:0]    mem_fwd_val,
	input  logic               wb_we,
	input  logic [REG_AW-1:0]  wb_wa,
	input  logic [XLEN-1:0]    wb_wd,
	output logic               ex_valid,
	output logic [XLEN-1:0]    ex_result,
	output logic [XLEN-1:0]    ex_store_data,
	output logic [REG_AW-1:0]  ex_rd,
	output logic               ex_reg_we,
	output logic               ex_store,
	output logic               ex_load,
	output logic [IMEM_AW-1:0] ex_pc
);

	logic [XLEN-1:0] fwd_a;
	logic [XLEN-1:0] fwd_b;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_y;

	// nearest producer wins, memory stage before writeback
	always_comb begin
		if (fwd_hit(mem_fwd_we, mem_fwd_rd, id_rs1))
			fwd_a = mem_fwd_val;
		else if (fwd_hit(wb_we, wb_wa, id_rs1))
			fwd_a = wb_wd;
		else
			fwd_a = id_op_a;

		if (fwd_hit(mem_fwd_we, mem_fwd_rd, id_rs2))
			fwd_b = mem_fwd_val;
		else if (fwd_hit(wb_we, wb_wa, id_rs2))
			fwd_b = wb_wd;
		else
			fwd_b = id_op_b_reg;
	end

	assign alu_b = id_use_imm ? id_imm : fwd_b;

	rv_alu u_alu (
		.op     (id_alu_op),
		.a      (fwd_a),
		.b      (alu_b),
		.result (alu_y)
	);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			ex_valid  <= 1'b0;
			ex_reg_we <= 1'b0;
			ex_store  <= 1'b0;
		end else begin
			ex_valid  <= id_valid;
			ex_reg_we <= id_reg_we;
			ex_store  <= id_store;
		end
	end

	// EX/MEM payload, store data takes the forwarded rs2
	always_ff @(posedge CLK) begin
		ex_result     <= alu_y;
		ex_store_data <= fwd_b;
		ex_rd         <= id_rd;
		ex_load       <= id_load;
		ex_pc         <= id_pc;
	end

endmodule

// File: verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; #(
	parameter int IMEM_AW = 12
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic [XLEN-1:0]    i_mem_rdata,
	output logic [IMEM_AW-1:0] i_mem_addr,
	output logic               if_valid,
	output logic [XLEN-1:0]    if_instr,
	output logic [IMEM_AW-1:0] if_pc
);

	logic [IMEM_AW-1:0] pc;

	assign i_mem_addr = pc;

	// sequential pc, no redirects in this core
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc       <= '0;
			if_valid <= 1'b0;
		end else begin
			pc       <= pc + IMEM_AW'(4);
			if_valid <= 1'b1;
		end
	end

	// IF/ID payload
	always_ff @(posedge CLK) begin
		if_instr <= i_mem_rdata;
		if_pc    <= pc;
	end

endmodule

// File: verilog/rv_mem_wb.sv
`timescale 1ns/1ps

module rv_mem_wb import rv_pkg::*; #(
	parameter int IMEM_AW = 12,
	parameter int DMEM_AW = 12
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               ex_valid,
	input  logic [XLEN-1:0]    ex_result,
	input  logic [XLEN-1:0]    ex_store_data,
	input  logic [REG_AW-1:0]  ex_rd,
	input  logic               ex_reg_we,
	input  logic               ex_store,
	input  logic               ex_load,
	input  logic [IMEM_AW-1:0] ex_pc,
	input  logic [XLEN-1:0]    d_mem_rdata,
	output logic [DMEM_AW-1:0] d_mem_addr,
	output logic [XLEN-1:0]    d_mem_wdata,
	output logic               d_mem_we,
	output logic               mem_fwd_we,
	output logic [REG_AW-1:0]  mem_fwd_rd,
	output logic [XLEN-1:0]    mem_fwd_val,
	output logic               rf_we,
	output logic [REG_AW-1:0]  rf_wa,
	output logic [XLEN-1:0]    rf_wd,
	output logic [31:0]        num_inst
);

	logic               wb_valid;
	logic               wb_reg_we;
	logic [REG_AW-1:0]  wb_rd;
	logic [XLEN-1:0]    wb_val;

	// word address from the byte address
	assign d_mem_addr  = ex_result[DMEM_AW+1:2];
	assign d_mem_wdata = ex_store_data;
	assign d_mem_we    = ex_valid && ex_store;

	// load data is already valid this cycle
	assign mem_fwd_we  = ex_valid && ex_reg_we;
	assign mem_fwd_rd  = ex_rd;
	assign mem_fwd_val = ex_load ? d_mem_rdata : ex_result;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wb_valid  <= 1'b0;
			wb_reg_we <= 1'b0;
		end else begin
			wb_valid  <= ex_valid;
			wb_reg_we <= mem_fwd_we;
		end
	end

	always_ff @(posedge CLK) begin
		wb_rd  <= ex_rd;
		wb_val <= mem_fwd_val;
	end

	assign rf_we = wb_valid && wb_reg_we;
	assign rf_wa = wb_rd;
	assign rf_wd = wb_val;

	// every valid slot retires, stores too
	always_ff @(posedge CLK) begin
		if (RSTn)
			num_inst <= '0;
		else if (wb_valid)
			num_inst <= num_inst + 32'd1;
	end

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

	// datapath and register file widths
	parameter int XLEN   = 32;
	parameter int REG_AW = 5;

	// major opcodes of the supported subset
	parameter logic [6:0] OP_R     = 7'b0110011;
	parameter logic [6:0] OP_IMM   = 7'b0010011;
	parameter logic [6:0] OP_LOAD  = 7'b0000011;
	parameter logic [6:0] OP_STORE = 7'b0100011;

	// funct3 codes for the integer ops
	parameter logic [2:0] F3_ADD  = 3'b000;
	parameter logic [2:0] F3_SLL  = 3'b001;
	parameter logic [2:0] F3_SLT  = 3'b010;
	parameter logic [2:0] F3_SLTU = 3'b011;
	parameter logic [2:0] F3_XOR  = 3'b100;
	parameter logic [2:0] F3_SR   = 3'b101;
	parameter logic [2:0] F3_OR   = 3'b110;
	parameter logic [2:0] F3_AND  = 3'b111;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	// producer hits a source register, x0 never forwards
	function automatic logic fwd_hit(
		input logic              we,
		input logic [REG_AW-1:0] rd,
		input logic [REG_AW-1:0] rs
	);
		return we && (rd != '0) && (rd == rs);
	endfunction

endpackage
